//--- ahbApbPkg.sv
/*
	AHB to APB bridge package
	bus widths, peripheral address map, AHB transfer codes and the
	APB controller state encoding
*/
`default_nettype none

package ahbApbPkg;

	////////////////////////////////////////////////////////////////////////////
	// bus widths
	localparam int addrWidth = 32;
	localparam int dataWidth = 32;
	localparam int numSlaves = 3; // one Pselx line per peripheral

	////////////////////////////////////////////////////////////////////////////
	// address map, three 64 MB windows
	localparam logic [addrWidth-1:0] slaveBase0  = 32'h8000_0000;
	localparam logic [addrWidth-1:0] slaveLimit0 = 32'h83FF_FFFC; // last word
	localparam logic [addrWidth-1:0] slaveBase1  = 32'h8400_0000;
	localparam logic [addrWidth-1:0] slaveLimit1 = 32'h87FF_FFFC;
	localparam logic [addrWidth-1:0] slaveBase2  = 32'h8800_0000;
	localparam logic [addrWidth-1:0] slaveLimit2 = 32'h8BFF_FFFC;

	// AHB transfer types
	localparam logic [1:0] htransIdle   = 2'b00;
	localparam logic [1:0] htransBusy   = 2'b01;
	localparam logic [1:0] htransNonseq = 2'b10;
	localparam logic [1:0] htransSeq    = 2'b11;

	localparam logic [1:0] hrespOkay = 2'b00;

	// APB controller states
	typedef enum logic [2:0] {
		stIdle     = 3'b000,
		stWwait    = 3'b001,
		stRead     = 3'b010,
		stWrite    = 3'b011,
		stWriteP   = 3'b100,
		stRenable  = 3'b101,
		stWenable  = 3'b110,
		stWenableP = 3'b111
	} apbState;

endpackage

`default_nettype wire

//--- ahbSlaveInterface.sv
/*
	AHB slave interface
	qualifies the AHB address phase, decodes the peripheral window and
	keeps two stages of address and write data for the APB controller
*/
`default_nettype none

module ahbSlaveInterface
	import ahbApbPkg::*;
(
	input  logic                 Hclk,
	input  logic                 Hresetn,
	input  logic                 Hwrite,
	input  logic                 Hreadyin,
	input  logic [1:0]           Htrans,
	input  logic [addrWidth-1:0] Haddr,
	input  logic [dataWidth-1:0] Hwdata,
	output logic                 valid,
	output logic [addrWidth-1:0] Haddr1,
	output logic [addrWidth-1:0] Haddr2,
	output logic [dataWidth-1:0] Hwdata1,
	output logic [dataWidth-1:0] Hwdata2,
	output logic                 Hwritereg,
	output logic [numSlaves-1:0] tempselx,
	output logic [1:0]           Hresp
);

	logic htransActive;

	////////////////////////////////////////////////////////////////////////////
	// address decode and transfer qualify

	// one select line per window
	assign tempselx[0] = (Haddr >= slaveBase0) && (Haddr <= slaveLimit0);
	assign tempselx[1] = (Haddr >= slaveBase1) && (Haddr <= slaveLimit1);
	assign tempselx[2] = (Haddr >= slaveBase2) && (Haddr <= slaveLimit2);

	assign htransActive = (Htrans == htransNonseq) || (Htrans == htransSeq);

	// unmapped addresses never reach the controller
	assign valid = Hreadyin && htransActive && (tempselx != '0);

	assign Hresp = hrespOkay; // no error responses

	////////////////////////////////////////////////////////////////////////////
	// pipeline stages

	always_ff @(posedge Hclk)
	begin
		Haddr1  <= Haddr;
		Haddr2  <= Haddr1;
		Hwdata1 <= Hwdata; // write data trails its address by a cycle
		Hwdata2 <= Hwdata1;
	end

	// direction of the transfer now in its data phase
	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			Hwritereg <= 1'b0;
		end
		else if (Hreadyin)
		begin
			Hwritereg <= Hwrite;
		end
	end

	// windows must never overlap
	selectOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn)
		$onehot0(tempselx));

endmodule

`default_nettype wire

//--- apbFsmController.sv
/*
	APB controller
	sequences APB setup and enable phases for each accepted AHB transfer
	and holds the AHB bus with Hreadyout while an APB access is pending
*/
`default_nettype none

module apbFsmController
	import ahbApbPkg::*;
(
	input  logic                 Hclk,
	input  logic                 Hresetn,
	input  logic                 valid,
	input  logic                 Hwrite,
	input  logic                 Hwritereg,
	input  logic [addrWidth-1:0] Haddr,
	input  logic [addrWidth-1:0] Haddr1,
	input  logic [addrWidth-1:0] Haddr2,
	input  logic [dataWidth-1:0] Hwdata,
	input  logic [dataWidth-1:0] Hwdata1,
	input  logic [dataWidth-1:0] Hwdata2,
	input  logic [dataWidth-1:0] Prdata,
	input  logic [numSlaves-1:0] tempselx,
	output logic                 Pwrite,
	output logic                 Penable,
	output logic [numSlaves-1:0] Pselx,
	output logic [addrWidth-1:0] Paddr,
	output logic [dataWidth-1:0] Pwdata,
	output logic                 Hreadyout
);

	apbState state;
	apbState nextState;

	logic [numSlaves-1:0] selx1; // select for Haddr1
	logic [numSlaves-1:0] selx2; // select for Haddr2

	logic                 pwriteNext;
	logic                 penableNext;
	logic [numSlaves-1:0] pselxNext;
	logic [addrWidth-1:0] paddrNext;
	logic [dataWidth-1:0] pwdataNext;
	logic                 hreadyoutNext;

	always_ff @(posedge Hclk)
	begin
		selx1 <= tempselx;
		selx2 <= selx1;
	end

	////////////////////////////////////////////////////////////////////////////
	// next state and next outputs

	always_comb
	begin
		nextState     = state;
		pwriteNext    = Pwrite;
		penableNext   = Penable;
		pselxNext     = Pselx;
		paddrNext     = Paddr;
		pwdataNext    = Pwdata;
		hreadyoutNext = Hreadyout;

		case (state)
			stIdle, stRenable, stWenable:
			begin
				penableNext = 1'b0;
				if (valid && !Hwrite)
				begin
					// read goes straight to setup
					nextState     = stRead;
					paddrNext     = Haddr;
					pwriteNext    = 1'b0;
					pselxNext     = tempselx;
					hreadyoutNext = 1'b0;
				end
				else if (valid)
				begin
					nextState     = stWwait; // wait for write data
					pselxNext     = '0;
					hreadyoutNext = 1'b1;
				end
				else
				begin
					nextState     = stIdle;
					pselxNext     = '0;
					hreadyoutNext = 1'b1;
				end
			end

			stWwait:
			begin
				// a transfer seen here is accepted and kept in Haddr2
				nextState     = valid ? stWriteP : stWrite;
				paddrNext     = Haddr1;
				pwdataNext    = Hwdata; // data phase of Haddr1 is on the bus now
				pwriteNext    = 1'b1;
				pselxNext     = selx1;
				penableNext   = 1'b0;
				hreadyoutNext = 1'b0;
			end

			stRead:
			begin
				nextState     = stRenable;
				penableNext   = 1'b1;
				hreadyoutNext = 1'b1;
			end

			stWrite:
			begin
				nextState     = valid ? stWenableP : stWenable;
				penableNext   = 1'b1;
				hreadyoutNext = 1'b1;
			end

			stWriteP:
			begin
				nextState     = stWenableP;
				penableNext   = 1'b1;
				hreadyoutNext = Hwritereg; // a pending read keeps the bus held
			end

			stWenableP:
			begin
				paddrNext     = Haddr2;
				pselxNext     = selx2;
				penableNext   = 1'b0;
				hreadyoutNext = 1'b0;
				if (Hwritereg)
				begin
					nextState  = valid ? stWriteP : stWrite;
					pwdataNext = Hwdata1;
					pwriteNext = 1'b1;
				end
				else
				begin
					nextState  = stRead;
					pwriteNext = 1'b0;
				end
			end

			default:
			begin
				nextState = stIdle;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// registers

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			state     <= stIdle;
			Pwrite    <= 1'b0;
			Penable   <= 1'b0;
			Pselx     <= '0;
			Hreadyout <= 1'b1; // master may start right after reset
		end
		else
		begin
			state     <= nextState;
			Pwrite    <= pwriteNext;
			Penable   <= penableNext;
			Pselx     <= pselxNext;
			Hreadyout <= hreadyoutNext;
		end
	end

	always_ff @(posedge Hclk)
	begin
		Paddr  <= paddrNext;
		Pwdata <= pwdataNext;
	end

	////////////////////////////////////////////////////////////////////////////
	// protocol checks

	penableAfterSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
		$rose(Penable) |-> $past(Pselx) != '0);

	setupHeldToEnable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(Pselx != '0 && !Penable) |=> (Penable && $stable(Pselx) && $stable(Paddr)));

	// read setup holds the bus, its enable releases it
	readThenEnable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(state == stRead) |-> (Pselx != '0 && !Penable && !Pwrite && !Hreadyout)
		##1 (state == stRenable && Penable && Hreadyout));

	// the word being written left the AHB bus two cycles earlier
	pipelinedWriteData: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(state == stWenableP) |-> (Pwdata == Hwdata2));

	// peripheral drives read data in its enable cycle
	readDataKnown: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(state == stRenable && !Pwrite) |-> !$isunknown(Prdata));

endmodule

`default_nettype wire

//--- ahbApbBridge.sv
/*
	AHB to APB bridge top level
	AHB slave interface feeding the APB controller, read data straight back
*/
`default_nettype none

module ahbApbBridge
	import ahbApbPkg::*;
(
	input  logic                 Hclk,
	input  logic                 Hresetn,
	input  logic                 Hwrite,
	input  logic                 Hreadyin,
	input  logic [1:0]           Htrans,
	input  logic [addrWidth-1:0] Haddr,
	input  logic [dataWidth-1:0] Hwdata,
	output logic                 Hreadyout,
	output logic [dataWidth-1:0] Hrdata,
	output logic [1:0]           Hresp,
	output logic [numSlaves-1:0] Pselx,
	output logic                 Penable,
	output logic                 Pwrite,
	output logic [addrWidth-1:0] Paddr,
	output logic [dataWidth-1:0] Pwdata,
	input  logic [dataWidth-1:0] Prdata
);

	logic                 valid;
	logic [addrWidth-1:0] Haddr1;
	logic [addrWidth-1:0] Haddr2;
	logic [dataWidth-1:0] Hwdata1;
	logic [dataWidth-1:0] Hwdata2;
	logic                 Hwritereg;
	logic [numSlaves-1:0] tempselx;

	// all connections share names with the ports above
	ahbSlaveInterface ahbIf (.*);

	apbFsmController apbCtrl (.*);

	assign Hrdata = Prdata; // read data is valid in the enable cycle

endmodule

`default_nettype wire

//--- ahbApbBridgeTb.sv
/*
	testbench for the AHB to APB bridge
	AHB master driver, three APB peripheral memories, protocol checks
*/
`default_nettype none

module ahbApbBridgeTb
	import ahbApbPkg::*;
();
	timeunit 1ns;
	timeprecision 1ns;

	logic                 Hclk;
	logic                 Hresetn;
	logic                 Hwrite;
	logic [1:0]           Htrans;
	logic [addrWidth-1:0] Haddr;
	logic [dataWidth-1:0] Hwdata;
	logic                 Hreadyout;
	logic [dataWidth-1:0] Hrdata;
	logic [1:0]           Hresp;
	logic [numSlaves-1:0] Pselx;
	logic                 Penable;
	logic                 Pwrite;
	logic [addrWidth-1:0] Paddr;
	logic [dataWidth-1:0] Pwdata;
	logic [dataWidth-1:0] Prdata;

	logic [31:0] mem [0:2][0:15]; // one 16-word memory per peripheral
	logic [7:0]  stepOp[$];
	logic [31:0] stepAddr[$];
	logic [31:0] stepData[$];
	int          stepTest[$];
	logic        expWrite[$]; // APB accesses still owed by the bridge
	logic [31:0] expAddr[$];
	logic [31:0] expData[$];

	int          errorCount = 0;
	int          checkCount = 0;
	int          testCount = 0;
	bit          stepsLoaded = 0;
	logic        wasSetup = 0;
	logic        readPending = 0;
	logic        lastActive = 0;
	logic [31:0] readExpect = '0;
	logic [31:0] lastWdata = '0;

	// single slave bus, so the bridge sees its own ready
	ahbApbBridge uut (
		.Hclk(Hclk), .Hresetn(Hresetn), .Hwrite(Hwrite), .Hreadyin(Hreadyout),
		.Htrans(Htrans), .Haddr(Haddr), .Hwdata(Hwdata), .Hreadyout(Hreadyout),
		.Hrdata(Hrdata), .Hresp(Hresp), .Pselx(Pselx), .Penable(Penable),
		.Pwrite(Pwrite), .Paddr(Paddr), .Pwdata(Pwdata), .Prdata(Prdata)
	);

	initial Hclk = 1'b0;
	always #20 Hclk = ~Hclk;

	// windows at 0x8000_0000, 0x8400_0000 and 0x8800_0000, 64 MB each
	function automatic logic inWindow(input logic [31:0] addr);
		return (addr[31:28] == 4'h8) && (addr[27:26] != 2'b11);
	endfunction

	function automatic logic [1:0] selIndex(input logic [numSlaves-1:0] sel);
		return sel[2] ? 2'd2 : (sel[1] ? 2'd1 : 2'd0);
	endfunction

	assign Prdata = (Pselx != '0 && !Pwrite) ? mem[selIndex(Pselx)][Paddr[5:2]] : '0;

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// APB peripheral model

	always @(negedge Hclk)
	begin
		if (!Hresetn)
		begin
			for (int s = 0; s < 3; s++)
				for (int w = 0; w < 16; w++)
					mem[2'(s)][4'(w)] = 32'hA5A5_0000 | 32'(s << 8) | 32'(w);
		end
		else
		begin
			if (Penable && !wasSetup)
			begin
				$display("APB error at %0t ns: Penable high without a setup cycle", $time);
				errorCount++;
			end
			if (Penable && Pselx != '0)
			begin
				if (expAddr.size() == 0)
				begin
					$display("APB error at %0t ns: access to %h that no AHB transfer asked for",
						$time, Paddr);
					errorCount++;
				end
				else
				begin
					checkValue("Pselx", 32'(1) << expAddr[0][27:26], 32'(Pselx));
					checkValue("Paddr", expAddr[0], Paddr);
					checkValue("Pwrite", 32'(expWrite[0]), 32'(Pwrite));
					if (expWrite[0])
						checkValue("Pwdata", expData[0], Pwdata);
					void'(expWrite.pop_front());
					void'(expAddr.pop_front());
					void'(expData.pop_front());
				end
				if (Pwrite)
					mem[selIndex(Pselx)][Paddr[5:2]] = Pwdata; // enable cycle of a write
			end
		end
		wasSetup = Hresetn && (Pselx != '0) && !Penable;
	end

	////////////////////////////////////////////////////////////////////////////
	// AHB master

	task automatic loadStimulus(output bit opened);
		int          fd;
		int          count;
		int          testNum;
		logic [1023:0] line;
		logic [7:0]  op;
		logic [31:0] addr;
		logic [31:0] data;
		fd = $fopen("ahbApbStimulus.txt", "r");
		opened = (fd != 0);
		if (opened)
		begin
			while (!$feof(fd))
			begin
				line = '0;
				if ($fgets(line, fd) != 0)
				begin
					count = $sscanf(line, "%s %h %h %d", op, addr, data, testNum);
					if (count == 4) // column header lines fail the hex field
					begin
						stepOp.push_back(op);
						stepAddr.push_back(addr);
						stepData.push_back(data);
						stepTest.push_back(testNum);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic issueStep(input logic [7:0] op, input logic [31:0] addr,
		input logic [31:0] data);
		logic active;
		active = (op != "I");
		@(negedge Hclk);
		Hwdata = lastWdata; // data phase of the step before
		Haddr  = addr;
		Hwrite = (op == "W");
		Htrans = !active ? htransIdle : (lastActive ? htransSeq : htransNonseq);
		if (active && inWindow(addr))
		begin
			expWrite.push_back(op == "W");
			expAddr.push_back(addr);
			expData.push_back(data);
		end
		while (!Hreadyout)
			@(negedge Hclk);
		checkValue("Hresp", 32'h0, 32'(Hresp)); // always OKAY
		if (readPending)
			checkValue("Hrdata", readExpect, Hrdata);
		readPending = (op == "R") && inWindow(addr);
		readExpect  = data;
		lastWdata   = (op == "W") ? data : '0;
		lastActive  = active;
	endtask

	// let the APB side catch up before a test is closed
	task automatic finishTest(input int testNum, input int errorsBefore);
		int waitCount;
		waitCount = 0;
		while (expAddr.size() != 0 && waitCount < 20)
		begin
			@(negedge Hclk);
			waitCount++;
		end
		if (expAddr.size() != 0)
		begin
			$display("APB error at %0t ns: %0d expected accesses never happened",
				$time, expAddr.size());
			errorCount++;
			expWrite.delete();
			expAddr.delete();
			expData.delete();
		end
		testCount++;
		$display("test %0d done at %0t ns, %0d errors, controller in %s", testNum, $time,
			errorCount - errorsBefore, uut.apbCtrl.state.name());
	endtask

	initial
	begin
		int curTest;
		int errorsBefore;
		bit opened;
		Hresetn = 1'b0;
		Hwrite  = 1'b0;
		Htrans  = htransIdle;
		Haddr   = '0;
		Hwdata  = '0;
		loadStimulus(opened);
		stepsLoaded = 1;
		repeat (16) @(negedge Hclk);
		Hresetn = 1'b1;
		@(negedge Hclk);
		checkValue("Hreadyout", 32'd1, 32'(Hreadyout));
		checkValue("Pselx", 32'd0, 32'(Pselx));
		checkValue("Penable", 32'd0, 32'(Penable));
		finishTest(1, 0);
		if (!opened)
		begin
			$display("stimulus file ahbApbStimulus.txt could not be opened");
			errorCount++;
		end
		else if (stepOp.size() != 0)
		begin
			curTest = stepTest[0];
			errorsBefore = errorCount;
			foreach (stepOp[i])
			begin
				if (stepTest[i] != curTest)
				begin
					finishTest(curTest, errorsBefore);
					curTest = stepTest[i];
					errorsBefore = errorCount;
				end
				issueStep(stepOp[i], stepAddr[i], stepData[i]);
			end
			finishTest(curTest, errorsBefore);
		end
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// watchdog, 40 cycles of 40 ns per stimulus line on top of reset
	initial
	begin
		wait (stepsLoaded);
		#(40 * (16 + 40 * stepOp.size()));
		$display("watchdog at %0t ns: the run did not finish in time, the bus seems hung", $time);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- ahbApbStimulus.txt
# op address data test
# op is W write, R read with the expected word, I idle
W 80000000 11111111 2
I 00000000 00000000 2
W 84000004 22222222 2
I 00000000 00000000 2
W 88000008 33333333 2
I 00000000 00000000 2
R 80000000 11111111 3
R 84000004 22222222 3
R 88000008 33333333 3
I 00000000 00000000 3
W 80000010 a0a0a0a0 4
W 84000014 b1b1b1b1 4
W 88000018 c2c2c2c2 4
W 8000001c d3d3d3d3 4
I 00000000 00000000 4
I 00000000 00000000 5
W 00000040 deadbeef 5
R 90000000 00000000 5
R 84000004 22222222 5
I 00000000 00000000 5
W 80000020 5a5a0001 6
R 80000020 5a5a0001 6
W 88000024 5a5a0002 6
R 88000024 5a5a0002 6
W 84000028 5a5a0003 6
R 84000028 5a5a0003 6
I 00000000 00000000 6

//--- all.f
ahbApbPkg.sv
ahbSlaveInterface.sv
apbFsmController.sv
ahbApbBridge.sv
ahbApbBridgeTb.sv

//--- Makefile
# Verilator flow for the AHB to APB bridge testbench
TOP = ahbApbBridgeTb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): all.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
